/* rvfi_checker.f */
rtl/rvfi_chk_pkg.sv
rtl/rvfi_retire_tracker.sv
rtl/rvfi_cause_check.sv
rtl/rvfi_error_log.sv
rtl/rvfi_checker.sv
testbench/tb_rvfi_checker.sv

/* Makefile */
# Verilator flow for the RVFI checker
# The simulation exits nonzero when the testbench stops with $fatal

TOP := tb_rvfi_checker

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f rvfi_checker.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rvfi_checker.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* testbench/tb_rvfi_checker.sv */
`default_nettype none

module tb_rvfi_checker;

  timeunit 1ns;
  timeprecision 1ps;

  import rvfi_chk_pkg::*;

  // Clock and reset timing
  localparam int unsigned CLK_HALF      = 5;
  localparam int unsigned CLK_PERIOD    = 2 * CLK_HALF;
  localparam int unsigned RESET_CYCLES  = 8;
  // Watchdog budget where each retirement takes its own cycle plus one idle cycle
  localparam int unsigned NUM_RESETS    = 3;
  localparam int unsigned NUM_RETIRE    = 24;
  localparam int unsigned RETIRE_CYCLES = 2;
  localparam int unsigned MARGIN_CYCLES = 50;
  localparam int unsigned TIMEOUT_NS    = CLK_PERIOD * (NUM_RESETS * (RESET_CYCLES + 1)
                                          + NUM_RETIRE * RETIRE_CYCLES + MARGIN_CYCLES);
  localparam logic [31:0] SEED          = 32'h21cca968;

  logic clk_i;
  logic rst_ni;

  // RVFI side played by the testbench
  logic                    rvfi_valid;
  logic [RF_ADDR_W-1:0]    rvfi_rs1_addr;
  logic [RF_ADDR_W-1:0]    rvfi_rs2_addr;
  logic [XLEN-1:0]         rvfi_rs1_rdata;
  logic [XLEN-1:0]         rvfi_rs2_rdata;
  logic [DBG_CAUSE_W-1:0]  rvfi_dbg;
  logic [XLEN-1:0]         rvfi_csr_dcsr_rdata;
  logic                    rvfi_trap_exception;
  logic [EXC_CAUSE_W-1:0]  rvfi_trap_exception_cause;
  logic                    rvfi_trap_debug;
  logic [DBG_CAUSE_W-1:0]  rvfi_trap_debug_cause;
  logic                    rvfi_intr_interrupt;
  logic [INTR_CAUSE_W-1:0] rvfi_intr_cause;
  logic [XLEN-1:0]         rvfi_csr_mcause_wdata;
  logic [XLEN-1:0]         rvfi_csr_mcause_wmask;
  logic                    rvfi_dbg_mode;

  // Error reporting of the DUT
  logic                    err_clear;
  logic                    err_valid;
  err_code_e               err_code;
  logic [NUM_CHECKS-1:0]   err_flags;
  logic [ERR_CNT_W-1:0]    err_count;

  // Expected log state
  err_code_e               exp_code_q;
  logic [NUM_CHECKS-1:0]   exp_flags;
  logic [ERR_CNT_W-1:0]    exp_count;

  rvfi_checker rvfi_checker_inst (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .rvfi_valid                (rvfi_valid),
    .rvfi_rs1_addr             (rvfi_rs1_addr),
    .rvfi_rs2_addr             (rvfi_rs2_addr),
    .rvfi_rs1_rdata            (rvfi_rs1_rdata),
    .rvfi_rs2_rdata            (rvfi_rs2_rdata),
    .rvfi_dbg                  (rvfi_dbg),
    .rvfi_csr_dcsr_rdata       (rvfi_csr_dcsr_rdata),
    .rvfi_trap_exception       (rvfi_trap_exception),
    .rvfi_trap_exception_cause (rvfi_trap_exception_cause),
    .rvfi_trap_debug           (rvfi_trap_debug),
    .rvfi_trap_debug_cause     (rvfi_trap_debug_cause),
    .rvfi_intr_interrupt       (rvfi_intr_interrupt),
    .rvfi_intr_cause           (rvfi_intr_cause),
    .rvfi_csr_mcause_wdata     (rvfi_csr_mcause_wdata),
    .rvfi_csr_mcause_wmask     (rvfi_csr_mcause_wmask),
    .rvfi_dbg_mode             (rvfi_dbg_mode),
    .err_clear                 (err_clear),
    .err_valid                 (err_valid),
    .err_code                  (err_code),
    .err_flags                 (err_flags),
    .err_count                 (err_count)
  );

  // 10 ns clock
  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  // Watchdog ends a hung run
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $fatal(1, "Timeout");
  end

  // Wrong value on a DUT output
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    $display("Finished with errors");
    $fatal(1, "Stopping at the first mismatch");
  endtask

  // Any other failed expectation
  task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    $display("Finished with errors");
    $fatal(1, "Stopping at the first failure");
  endtask

  // One-hot violation vector for a check index
  function automatic logic [NUM_CHECKS-1:0] viol_bit(input int unsigned idx);
    viol_bit = '0;
    viol_bit[idx] = 1'b1;
  endfunction

  // Idle RVFI with no retirement
  task automatic clear_inputs();
    rvfi_valid                = 1'b0;
    rvfi_rs1_addr             = '0;
    rvfi_rs2_addr             = '0;
    rvfi_rs1_rdata            = '0;
    rvfi_rs2_rdata            = '0;
    rvfi_dbg                  = '0;
    rvfi_csr_dcsr_rdata       = '0;
    rvfi_trap_exception       = 1'b0;
    rvfi_trap_exception_cause = '0;
    rvfi_trap_debug           = 1'b0;
    rvfi_trap_debug_cause     = '0;
    rvfi_intr_interrupt       = 1'b0;
    rvfi_intr_cause           = '0;
    rvfi_csr_mcause_wdata     = '0;
    rvfi_csr_mcause_wmask     = '0;
    rvfi_dbg_mode             = 1'b0;
    err_clear                 = 1'b0;
  endtask

  // Compare all outputs at a falling edge where they are stable
  task automatic check_outputs(input logic exp_valid);
    assert (err_valid === exp_valid)
      else report_mismatch("err_valid", 32'(err_valid), 32'(exp_valid));
    assert (err_code === exp_code_q)
      else report_mismatch("err_code", 32'(err_code), 32'(exp_code_q));
    assert (err_flags === exp_flags)
      else report_mismatch("err_flags", 32'(err_flags), 32'(exp_flags));
    assert (err_count === exp_count)
      else report_mismatch("err_count", 32'(err_count), 32'(exp_count));
  endtask

  // Reset held for 8 cycles before the reset values are checked
  task automatic apply_reset();
    rst_ni = 1'b0;
    clear_inputs();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni     = 1'b1;
    exp_code_q = ERR_NONE;
    exp_flags  = '0;
    exp_count  = '0;
    check_outputs(1'b0);
  endtask

  // Fields are already set by the caller at a falling edge
  // One retirement with the result one edge later and the strobe gone one edge after that
  task automatic retire(input logic [NUM_CHECKS-1:0] exp_viol, input err_code_e exp_code);
    rvfi_valid = 1'b1;
    @(posedge clk_i);
    if (exp_viol != '0) begin
      exp_code_q = exp_code;
    end
    // Clear beats a same-cycle violation for flags and count
    if (err_clear) begin
      exp_flags = '0;
      exp_count = '0;
    end else begin
      exp_flags = exp_flags | exp_viol;
      exp_count = exp_count + ERR_CNT_W'($countones(exp_viol));
    end
    @(negedge clk_i);
    clear_inputs();
    check_outputs(exp_viol != '0);
    @(posedge clk_i);
    @(negedge clk_i);
    check_outputs(1'b0);
  endtask

  // Register reads must be zero on the first retirement only
  task automatic test_reset_values();
    logic [RF_ADDR_W-1:0] addr;
    logic [XLEN-1:0]      data;
    addr = RF_ADDR_W'(1 + $urandom % 31);
    data = $urandom | 32'h1;
    rvfi_rs1_addr  = addr;
    rvfi_rs1_rdata = data;
    retire(viol_bit(CHK_RS1_RESET), ERR_RS1_RESET);
    // Same data later is legal
    rvfi_rs1_addr  = addr;
    rvfi_rs1_rdata = data;
    retire('0, ERR_NONE);
    // Fresh reset where x0 may read anything and a zero read is fine
    apply_reset();
    rvfi_rs2_addr  = '0;
    rvfi_rs2_rdata = $urandom | 32'h1;
    rvfi_rs1_addr  = addr;
    rvfi_rs1_rdata = '0;
    retire('0, ERR_NONE);
    // Another reset with rs2 naming a real register
    apply_reset();
    rvfi_rs2_addr  = addr;
    rvfi_rs2_rdata = data;
    retire(viol_bit(CHK_RS2_RESET), ERR_RS2_RESET);
  endtask

  // Debug entry cause against dcsr
  task automatic test_dbg_cause();
    logic [DBG_CAUSE_W-1:0] cause;
    logic [XLEN-1:0]        dcsr;
    cause = DBG_CAUSE_W'(1 + $urandom % 7);
    dcsr  = $urandom;
    dcsr[DCSR_CAUSE_MSB:DCSR_CAUSE_LSB] = cause;
    rvfi_dbg            = cause;
    rvfi_csr_dcsr_rdata = dcsr;
    retire('0, ERR_NONE);
    // Inverted field always differs
    dcsr[DCSR_CAUSE_MSB:DCSR_CAUSE_LSB] = ~cause;
    rvfi_dbg            = cause;
    rvfi_csr_dcsr_rdata = dcsr;
    retire(viol_bit(CHK_DBG_CAUSE), ERR_DBG_CAUSE);
    // Retire one instruction in debug mode
    rvfi_dbg_mode = 1'b1;
    retire('0, ERR_NONE);
    // Mismatch ignored right after a retirement in debug mode
    rvfi_dbg            = cause;
    rvfi_csr_dcsr_rdata = dcsr;
    rvfi_dbg_mode       = 1'b0;
    retire('0, ERR_NONE);
  endtask

  // Exception cause against the masked mcause write
  task automatic test_exc_cause();
    logic [EXC_CAUSE_W-1:0] cause;
    logic [XLEN-1:0]        mask;
    logic [XLEN-1:0]        wdata;
    // Range 2..63 so that flipping bit 0 stays nonzero
    cause = EXC_CAUSE_W'(2 + $urandom % 62);
    mask  = $urandom | 32'(cause);
    // Random bits only outside the mask
    wdata = 32'(cause) | ($urandom & ~mask);
    rvfi_trap_exception       = 1'b1;
    rvfi_trap_exception_cause = cause;
    rvfi_csr_mcause_wdata     = wdata;
    rvfi_csr_mcause_wmask     = mask;
    retire('0, ERR_NONE);
    rvfi_trap_exception       = 1'b1;
    rvfi_trap_exception_cause = cause ^ 6'h01;
    rvfi_csr_mcause_wdata     = wdata;
    rvfi_csr_mcause_wmask     = mask;
    retire(viol_bit(CHK_EXC_CAUSE), ERR_EXC_CAUSE);
    // mcause is not written in debug mode
    rvfi_trap_exception       = 1'b1;
    rvfi_trap_exception_cause = cause ^ 6'h01;
    rvfi_csr_mcause_wdata     = wdata;
    rvfi_csr_mcause_wmask     = mask;
    rvfi_dbg_mode             = 1'b1;
    retire('0, ERR_NONE);
    retire('0, ERR_NONE);
  endtask

  // Traps with a zero cause alone and combined
  task automatic test_missing_cause();
    rvfi_trap_exception = 1'b1;
    retire(viol_bit(CHK_EXC_NOCAUSE), ERR_EXC_NOCAUSE);
    rvfi_intr_interrupt = 1'b1;
    retire(viol_bit(CHK_INTR_NOCAUSE), ERR_INTR_NOCAUSE);
    rvfi_trap_debug = 1'b1;
    retire(viol_bit(CHK_DBG_NOCAUSE), ERR_DBG_NOCAUSE);
    // Zero cause against a nonzero mcause write fails four checks
    rvfi_trap_exception   = 1'b1;
    rvfi_csr_mcause_wdata = 32'h5;
    rvfi_csr_mcause_wmask = '1;
    rvfi_intr_interrupt   = 1'b1;
    rvfi_trap_debug       = 1'b1;
    retire(viol_bit(CHK_EXC_CAUSE) | viol_bit(CHK_EXC_NOCAUSE)
           | viol_bit(CHK_INTR_NOCAUSE) | viol_bit(CHK_DBG_NOCAUSE), ERR_EXC_CAUSE);
  endtask

  // Sticky flags, idle cycles and clear
  task automatic test_log_behavior();
    assert (err_flags[CHK_DBG_CAUSE] && err_flags[CHK_DBG_NOCAUSE])
      else report_failure("err_flags lost flags set by earlier tests");
    // Bad data without rvfi_valid
    rvfi_trap_exception = 1'b1;
    rvfi_intr_interrupt = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    clear_inputs();
    check_outputs(1'b0);
    // Clear alone
    err_clear = 1'b1;
    @(posedge clk_i);
    exp_flags = '0;
    exp_count = '0;
    @(negedge clk_i);
    clear_inputs();
    check_outputs(1'b0);
    // Clear together with a violation still fires the strobe
    err_clear           = 1'b1;
    rvfi_intr_interrupt = 1'b1;
    retire(viol_bit(CHK_INTR_NOCAUSE), ERR_INTR_NOCAUSE);
    // Counting resumes after the clear
    rvfi_trap_exception = 1'b1;
    retire(viol_bit(CHK_EXC_NOCAUSE), ERR_EXC_NOCAUSE);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni     = 1'b0;
    exp_code_q = ERR_NONE;
    exp_flags  = '0;
    exp_count  = '0;
    clear_inputs();
    apply_reset();
    test_reset_values();
    test_dbg_cause();
    test_exc_cause();
    test_missing_cause();
    test_log_behavior();
    $display("Finished with no errors");
    $finish;
  end

endmodule : tb_rvfi_checker

`default_nettype wire

/* rtl/rvfi_checker.sv */
`default_nettype none

module rvfi_checker (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  // RVFI retirement port
  input  logic                                   rvfi_valid,
  input  logic [rvfi_chk_pkg::RF_ADDR_W-1:0]     rvfi_rs1_addr,
  input  logic [rvfi_chk_pkg::RF_ADDR_W-1:0]     rvfi_rs2_addr,
  input  logic [rvfi_chk_pkg::XLEN-1:0]          rvfi_rs1_rdata,
  input  logic [rvfi_chk_pkg::XLEN-1:0]          rvfi_rs2_rdata,
  input  logic [rvfi_chk_pkg::DBG_CAUSE_W-1:0]   rvfi_dbg,
  input  logic [rvfi_chk_pkg::XLEN-1:0]          rvfi_csr_dcsr_rdata,
  input  logic                                   rvfi_trap_exception,
  input  logic [rvfi_chk_pkg::EXC_CAUSE_W-1:0]   rvfi_trap_exception_cause,
  input  logic                                   rvfi_trap_debug,
  input  logic [rvfi_chk_pkg::DBG_CAUSE_W-1:0]   rvfi_trap_debug_cause,
  input  logic                                   rvfi_intr_interrupt,
  input  logic [rvfi_chk_pkg::INTR_CAUSE_W-1:0]  rvfi_intr_cause,
  input  logic [rvfi_chk_pkg::XLEN-1:0]          rvfi_csr_mcause_wdata,
  input  logic [rvfi_chk_pkg::XLEN-1:0]          rvfi_csr_mcause_wmask,
  input  logic                                   rvfi_dbg_mode,

  // Error reporting
  input  logic                                   err_clear,
  output logic                                   err_valid,
  output rvfi_chk_pkg::err_code_e                err_code,
  output logic [rvfi_chk_pkg::NUM_CHECKS-1:0]    err_flags,
  output logic [rvfi_chk_pkg::ERR_CNT_W-1:0]     err_count
);

  import rvfi_chk_pkg::*;

  // Tracker to checks
  logic                  first_retire;
  logic                  was_dbg_mode;
  // Checks to log
  logic [NUM_CHECKS-1:0] violations;

  // Retirement history
  rvfi_retire_tracker rvfi_retire_tracker_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid    (rvfi_valid),
    .rvfi_dbg_mode (rvfi_dbg_mode),
    .first_retire  (first_retire),
    .was_dbg_mode  (was_dbg_mode)
  );

  // Per-retirement consistency rules
  rvfi_cause_check rvfi_cause_check_inst (
    .rvfi_valid                (rvfi_valid),
    .rvfi_rs1_addr             (rvfi_rs1_addr),
    .rvfi_rs2_addr             (rvfi_rs2_addr),
    .rvfi_rs1_rdata            (rvfi_rs1_rdata),
    .rvfi_rs2_rdata            (rvfi_rs2_rdata),
    .rvfi_dbg                  (rvfi_dbg),
    .rvfi_csr_dcsr_rdata       (rvfi_csr_dcsr_rdata),
    .rvfi_trap_exception       (rvfi_trap_exception),
    .rvfi_trap_exception_cause (rvfi_trap_exception_cause),
    .rvfi_trap_debug           (rvfi_trap_debug),
    .rvfi_trap_debug_cause     (rvfi_trap_debug_cause),
    .rvfi_intr_interrupt       (rvfi_intr_interrupt),
    .rvfi_intr_cause           (rvfi_intr_cause),
    .rvfi_csr_mcause_wdata     (rvfi_csr_mcause_wdata),
    .rvfi_csr_mcause_wmask     (rvfi_csr_mcause_wmask),
    .rvfi_dbg_mode             (rvfi_dbg_mode),
    .first_retire              (first_retire),
    .was_dbg_mode              (was_dbg_mode),
    .violations                (violations)
  );

  // Registered reporting, one cycle behind the retirement
  rvfi_error_log rvfi_error_log_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .violations (violations),
    .err_clear  (err_clear),
    .err_valid  (err_valid),
    .err_code   (err_code),
    .err_flags  (err_flags),
    .err_count  (err_count)
  );

endmodule : rvfi_checker

`default_nettype wire

/* rtl/rvfi_error_log.sv */
`default_nettype none

module rvfi_error_log (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Violation vector of the current retirement
  input  logic [rvfi_chk_pkg::NUM_CHECKS-1:0]  violations,
  // Clears the sticky flags and the counter
  input  logic                                 err_clear,

  // One-cycle error strobe
  output logic                                 err_valid,
  // Lowest violated check, held until the next strobe
  output rvfi_chk_pkg::err_code_e              err_code,
  // Sticky per-check flags
  output logic [rvfi_chk_pkg::NUM_CHECKS-1:0]  err_flags,
  // Saturating number of violations
  output logic [rvfi_chk_pkg::ERR_CNT_W-1:0]   err_count
);

  import rvfi_chk_pkg::*;

  // Width large enough to count all checks at once
  localparam int unsigned POP_W = $clog2(NUM_CHECKS + 1);

  err_code_e            code_next;
  logic [POP_W-1:0]     pop_cnt;
  logic [ERR_CNT_W:0]   cnt_sum;
  logic [ERR_CNT_W-1:0] cnt_next;

  // Priority encode, lowest index wins
  // Loop runs downwards so the last hit is the lowest bit
  always_comb begin
    code_next = ERR_NONE;
    for (int i = NUM_CHECKS - 1; i >= 0; i--) begin
      if (violations[i]) begin
        code_next = err_code_e'(ERR_CODE_W'(i + 1));
      end
    end
  end

  // Number of checks violated by this retirement
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < NUM_CHECKS; i++) begin
      pop_cnt = pop_cnt + POP_W'(violations[i]);
    end
  end

  // Add with one carry bit, clamp on overflow
  assign cnt_sum  = {1'b0, err_count} + (ERR_CNT_W + 1)'(pop_cnt);
  assign cnt_next = cnt_sum[ERR_CNT_W] ? '1 : cnt_sum[ERR_CNT_W-1:0];

  // Strobe and code
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid <= 1'b0;
      err_code  <= ERR_NONE;
    end else begin
      err_valid <= |violations;
      // Code only updates with a new strobe
      if (|violations) begin
        err_code <= code_next;
      end
    end
  end

  // Flags and counter, clear has priority over new violations
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_flags <= '0;
      err_count <= '0;
    end else if (err_clear) begin
      err_flags <= '0;
      err_count <= '0;
    end else begin
      err_flags <= err_flags | violations;
      err_count <= cnt_next;
    end
  end

  // A strobe always carries a real code
  a_valid_has_code: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    err_valid |-> (err_code != ERR_NONE)
  ) else $error("err_valid with ERR_NONE");

  // Counter is monotonic between clears
  a_count_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !err_clear |=> (err_count >= $past(err_count))
  ) else $error("err_count decreased without err_clear");

endmodule : rvfi_error_log

`default_nettype wire

/* rtl/rvfi_cause_check.sv */
`default_nettype none

module rvfi_cause_check (
  // Retirement strobe, qualifies every other input
  input  logic                                    rvfi_valid,

  // Source operands of the retiring instruction
  input  logic [rvfi_chk_pkg::RF_ADDR_W-1:0]      rvfi_rs1_addr,
  input  logic [rvfi_chk_pkg::RF_ADDR_W-1:0]      rvfi_rs2_addr,
  input  logic [rvfi_chk_pkg::XLEN-1:0]           rvfi_rs1_rdata,
  input  logic [rvfi_chk_pkg::XLEN-1:0]           rvfi_rs2_rdata,

  // Debug entry cause and dcsr as read
  input  logic [rvfi_chk_pkg::DBG_CAUSE_W-1:0]    rvfi_dbg,
  input  logic [rvfi_chk_pkg::XLEN-1:0]           rvfi_csr_dcsr_rdata,

  // Trap fields
  input  logic                                    rvfi_trap_exception,
  input  logic [rvfi_chk_pkg::EXC_CAUSE_W-1:0]    rvfi_trap_exception_cause,
  input  logic                                    rvfi_trap_debug,
  input  logic [rvfi_chk_pkg::DBG_CAUSE_W-1:0]    rvfi_trap_debug_cause,

  // Interrupt fields
  input  logic                                    rvfi_intr_interrupt,
  input  logic [rvfi_chk_pkg::INTR_CAUSE_W-1:0]   rvfi_intr_cause,

  // mcause write as seen at retirement
  input  logic [rvfi_chk_pkg::XLEN-1:0]           rvfi_csr_mcause_wdata,
  input  logic [rvfi_chk_pkg::XLEN-1:0]           rvfi_csr_mcause_wmask,

  input  logic                                    rvfi_dbg_mode,

  // History from the retirement tracker
  input  logic                                    first_retire,
  input  logic                                    was_dbg_mode,

  // One bit per check, set on violation
  output logic [rvfi_chk_pkg::NUM_CHECKS-1:0]     violations
);

  import rvfi_chk_pkg::*;

  // Cause field of dcsr
  logic [DBG_CAUSE_W-1:0] dcsr_cause;
  // Exception cause widened to the CSR width
  logic [XLEN-1:0]        exc_cause_ext;
  // Value the core actually wrote into mcause
  logic [XLEN-1:0]        mcause_written;

  assign dcsr_cause     = rvfi_csr_dcsr_rdata[DCSR_CAUSE_MSB:DCSR_CAUSE_LSB];
  assign exc_cause_ext  = {{(XLEN-EXC_CAUSE_W){1'b0}}, rvfi_trap_exception_cause};
  assign mcause_written = rvfi_csr_mcause_wdata & rvfi_csr_mcause_wmask;

  // Each rule carries its own rvfi_valid qualifier
  always_comb begin
    violations = '0;

    // Register file reads zero right after reset
    violations[CHK_RS1_RESET] = rvfi_valid && first_retire
                                && (rvfi_rs1_addr != '0) && (rvfi_rs1_rdata != '0);
    violations[CHK_RS2_RESET] = rvfi_valid && first_retire
                                && (rvfi_rs2_addr != '0) && (rvfi_rs2_rdata != '0);

    // Debug entry cause must match dcsr
    // Skipped when already in debug since dcsr is not rewritten then
    violations[CHK_DBG_CAUSE] = rvfi_valid && (rvfi_dbg != '0) && !was_dbg_mode
                                && (rvfi_dbg != dcsr_cause);

    // Exception cause must match the mcause write
    // In debug mode mcause is left alone
    violations[CHK_EXC_CAUSE] = rvfi_valid && rvfi_trap_exception && !rvfi_dbg_mode
                                && (exc_cause_ext != mcause_written);

    // Every trap kind needs a nonzero cause
    violations[CHK_EXC_NOCAUSE]  = rvfi_valid && rvfi_trap_exception
                                   && (rvfi_trap_exception_cause == '0);
    violations[CHK_INTR_NOCAUSE] = rvfi_valid && rvfi_intr_interrupt
                                   && (rvfi_intr_cause == '0);
    violations[CHK_DBG_NOCAUSE]  = rvfi_valid && rvfi_trap_debug
                                   && (rvfi_trap_debug_cause == '0);

    // No rule may fire outside a retirement
    if (!rvfi_valid) begin
      a_no_violation_idle: assert (violations == '0)
        else $error("violation flagged without rvfi_valid");
    end
  end

endmodule : rvfi_cause_check

`default_nettype wire

/* rtl/rvfi_retire_tracker.sv */
`default_nettype none

module rvfi_retire_tracker (
  input  logic clk_i,
  input  logic rst_ni,

  // Retirement strobe and debug mode of the retiring instruction
  input  logic rvfi_valid,
  input  logic rvfi_dbg_mode,

  // History towards the cause checks
  output logic first_retire,
  output logic was_dbg_mode
);

  // First-retirement flag
  // Set by reset, stays high through the first valid cycle
  // so the checks see it during that retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_retire <= 1'b1;
    end else if (rvfi_valid) begin
      // Once cleared, only reset sets it again
      first_retire <= 1'b0;
    end
  end

  // Debug mode of the previous retirement
  // Held between retirements so gaps in rvfi_valid do not disturb it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Core leaves reset outside debug mode
      was_dbg_mode <= 1'b0;
    end else if (rvfi_valid) begin
      was_dbg_mode <= rvfi_dbg_mode;
    end
  end

  // Reset-value checks must apply to one retirement only
  // The flag may only fall and a rise needs a reset
  a_first_retire_no_rise: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !first_retire |=> !first_retire
  ) else $error("first_retire rose again without a reset");

endmodule : rvfi_retire_tracker

`default_nettype wire

/* rtl/rvfi_chk_pkg.sv */
`default_nettype none

package rvfi_chk_pkg;

  // Datapath widths of the RVFI retirement port
  localparam int unsigned XLEN      = 32;
  localparam int unsigned RF_ADDR_W = 5;

  // Cause field widths as carried on RVFI
  localparam int unsigned EXC_CAUSE_W  = 6;
  localparam int unsigned INTR_CAUSE_W = 11;
  localparam int unsigned DBG_CAUSE_W  = 3;

  // Location of the cause field inside dcsr
  localparam int unsigned DCSR_CAUSE_LSB = 6;
  localparam int unsigned DCSR_CAUSE_MSB = 8;

  // Width of the saturating error counter
  localparam int unsigned ERR_CNT_W = 16;

  // Number of consistency checks
  localparam int unsigned NUM_CHECKS = 7;

  // Bit positions in the violation vector
  // Lower index means higher reporting priority
  localparam int unsigned CHK_RS1_RESET    = 0;
  localparam int unsigned CHK_RS2_RESET    = 1;
  localparam int unsigned CHK_DBG_CAUSE    = 2;
  localparam int unsigned CHK_EXC_CAUSE    = 3;
  localparam int unsigned CHK_EXC_NOCAUSE  = 4;
  localparam int unsigned CHK_INTR_NOCAUSE = 5;
  localparam int unsigned CHK_DBG_NOCAUSE  = 6;

  // Width of the error code
  localparam int unsigned ERR_CODE_W = 3;

  // Error codes, each one above its check index
  typedef enum logic [ERR_CODE_W-1:0] {
    ERR_NONE         = 3'd0,
    ERR_RS1_RESET    = 3'd1,
    ERR_RS2_RESET    = 3'd2,
    ERR_DBG_CAUSE    = 3'd3,
    ERR_EXC_CAUSE    = 3'd4,
    ERR_EXC_NOCAUSE  = 3'd5,
    ERR_INTR_NOCAUSE = 3'd6,
    ERR_DBG_NOCAUSE  = 3'd7
  } err_code_e;

endpackage : rvfi_chk_pkg

`default_nettype wire
